//--- verilog/riscv_pkg.sv
// ISA level definitions shared by the fetch side and the resolve side
// only the control transfer opcodes matter to the predictor, so the rest of
// the RV32I opcode map is left out on purpose
package riscv_pkg;

    // a pc, a branch target or a raw instruction word
    typedef logic [31:0] word_t;

    // the major opcode sits in instruction bits 6:0
    typedef logic [6:0] opcode_t;

    // conditional branches (beq, bne, blt, bge, bltu, bgeu) share one major opcode
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // jal is a pc relative unconditional jump
    localparam opcode_t OP_JAL = 7'b1101111;

    // jalr jumps through a register, which makes its target the hardest to predict
    // the BTB still caches the last target seen for it
    localparam opcode_t OP_JALR = 7'b1100111;

    // instructions are four bytes wide without the compressed extension
    // so the two low pc bits never carry index or tag information

endpackage

//--- verilog/bpred_pkg.sv
// definitions that describe the direction predictor and nothing about the ISA
// the pattern history table holds one of these counters per entry
package bpred_pkg;

    // two bit saturating counter
    // 00 strongly not taken, 01 weakly not taken
    // 10 weakly taken, 11 strongly taken
    // the upper bit alone is the taken prediction
    typedef logic [1:0] ctr_t;

    // every counter leaves reset weakly not taken, so one taken outcome is
    // enough to flip the prediction of a fresh entry
    localparam ctr_t CTR_RESET = 2'b01;

    // an increment stops here
    localparam ctr_t CTR_MAX = 2'b11;

    // a decrement stops here
    localparam ctr_t CTR_MIN = 2'b00;

    // with these thresholds a strongly biased branch needs two wrong
    // outcomes in a row before its prediction changes

endpackage

//--- verilog/branch_target_buffer.sv
`timescale 1ns/100ps

// direct mapped branch target buffer
// one entry per index, each with a tag, a target and a valid bit
// lookup is combinational for the fetch pc, install happens at the clock edge
module branch_target_buffer #(
    parameter int BTB_ENTRIES = 64
) (
    input  logic              clk,
    input  logic              reset_i,
    input  riscv_pkg::word_t  lookup_pc_i,
    output logic              hit_o,
    output riscv_pkg::word_t  target_o,
    input  logic              we_i,
    input  riscv_pkg::word_t  write_pc_i,
    input  riscv_pkg::word_t  write_target_i
);

    // index bits sit right above the two byte offset bits of the pc
    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    // the tag is every pc bit above the index
    localparam int TAG_BITS = 30 - IDX_BITS;

    typedef logic [IDX_BITS-1:0] btb_idx_t;
    typedef logic [TAG_BITS-1:0] btb_tag_t;

    // storage for tags and targets, valid bits kept apart so reset only
    // has to touch one bit per entry
    btb_tag_t          tag_q    [BTB_ENTRIES];
    riscv_pkg::word_t  target_q [BTB_ENTRIES];
    logic              valid_q  [BTB_ENTRIES];

    btb_idx_t  lookup_idx;
    btb_tag_t  lookup_tag;
    btb_idx_t  write_idx;
    btb_tag_t  write_tag;

    // split the fetch pc into index and tag
    assign lookup_idx = lookup_pc_i[IDX_BITS+1:2];
    assign lookup_tag = lookup_pc_i[31:IDX_BITS+2];

    // the same split for the pc being installed from execute
    assign write_idx = write_pc_i[IDX_BITS+1:2];
    assign write_tag = write_pc_i[31:IDX_BITS+2];

    // a hit needs both a live entry and a matching tag
    // otherwise a pc that aliases onto the same index would steal the target
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    // the target is read out unconditionally, the top level decides whether to use it
    assign target_o = target_q[lookup_idx];

    // valid bits are the only control state of the table
    // reset walks every entry, an install marks the written entry live
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (we_i) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    // tag and target follow the valid bit on an install
    // an install into a live entry simply replaces the older branch
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[write_idx]    <= write_tag;
            target_q[write_idx] <= write_target_i;
        end
    end

    // targets come from resolved jumps and branches in execute, and without
    // compressed instructions they must land on a word boundary
    // a misaligned value here points at a bad target computation upstream
    property p_target_aligned;
        @(posedge clk) disable iff (reset_i)
        we_i |-> (write_target_i[1:0] == 2'b00);
    endproperty

    a_target_aligned: assert property (p_target_aligned)
        else $error("btb install of misaligned target %h", write_target_i);

endmodule

//--- verilog/gshare_predictor.sv
`timescale 1ns/100ps

// gshare direction predictor
// a global history register of recent branch outcomes is XORed with the pc
// to pick one two bit counter out of the pattern history table
module gshare_predictor #(
    parameter int GHR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  riscv_pkg::word_t     lookup_pc_i,
    output logic [GHR_BITS-1:0]  read_index_o,
    output logic                 predict_taken_o,
    input  logic                 ghr_clear_i,
    input  logic                 we_i,
    input  logic                 increment_i,
    input  logic [GHR_BITS-1:0]  write_index_i
);

    import bpred_pkg::*;

    // one counter for every history value
    localparam int PHT_ENTRIES = 1 << GHR_BITS;

    typedef logic [GHR_BITS-1:0] pht_idx_t;

    // newest outcome lives in bit 0, the oldest in the top bit
    pht_idx_t  ghr_q;
    ctr_t      pht_q [PHT_ENTRIES];

    // counter at the write index and the value it moves to
    ctr_t      wr_ctr;
    ctr_t      wr_ctr_next;

    // hash the history with the word address of the fetch pc
    // the index leaves with the prediction so execute can train the same entry
    assign read_index_o = ghr_q ^ lookup_pc_i[GHR_BITS+1:2];

    // upper counter bit means taken
    assign predict_taken_o = pht_q[read_index_o][1];

    assign wr_ctr = pht_q[write_index_i];

    // saturating step
    // a taken outcome climbs toward CTR_MAX, a not taken one falls toward CTR_MIN
    always_comb begin
        wr_ctr_next = wr_ctr;
        if (increment_i) begin
            if (wr_ctr != CTR_MAX) begin
                wr_ctr_next = ctr_t'(wr_ctr + 2'd1);
            end
        end else begin
            if (wr_ctr != CTR_MIN) begin
                wr_ctr_next = ctr_t'(wr_ctr - 2'd1);
            end
        end
    end

    // history register
    // a clear from outside beats a shift in the same cycle, so the outcome
    // of that branch is dropped from the history
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (we_i) begin
            ghr_q <= {ghr_q[GHR_BITS-2:0], increment_i};
        end
    end

    // the counters are predictor state, so reset puts every one of them
    // back to weakly not taken
    // the history clear leaves them alone and only the hash changes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= CTR_RESET;
            end
        end else if (we_i) begin
            pht_q[write_index_i] <= wr_ctr_next;
        end
    end

    // one edge after a write the trained entry has never moved against the
    // outcome, so a taken outcome cannot wrap CTR_MAX over to CTR_MIN
    // and a not taken one cannot wrap CTR_MIN over to CTR_MAX
    property p_counter_step;
        @(posedge clk) disable iff (reset_i)
        we_i |=> ($past(increment_i) ? (pht_q[$past(write_index_i)] >= $past(wr_ctr))
                                      : (pht_q[$past(write_index_i)] <= $past(wr_ctr)));
    endproperty

    a_counter_step: assert property (p_counter_step)
        else $error("pht counter wrapped past its saturation limit after update");

endmodule

//--- verilog/bpred_update_ctrl.sv
`timescale 1ns/100ps

// update controller
// captures one resolved control transfer per strobe, trains both tables
// from that registered copy in the next cycle and reports a misprediction
module bpred_update_ctrl #(
    parameter int GHR_BITS = 6
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 resolve_valid_i,
    input  riscv_pkg::word_t     resolve_pc_i,
    input  riscv_pkg::opcode_t   resolve_op_i,
    input  logic                 resolve_taken_i,
    input  riscv_pkg::word_t     resolve_target_i,
    input  logic [GHR_BITS-1:0]  resolve_pht_index_i,
    input  logic                 resolve_pred_taken_i,
    input  riscv_pkg::word_t     resolve_pred_target_i,
    output logic                 btb_we_o,
    output riscv_pkg::word_t     btb_pc_o,
    output riscv_pkg::word_t     btb_target_o,
    output logic                 pht_we_o,
    output logic                 pht_increment_o,
    output logic [GHR_BITS-1:0]  pht_index_o,
    output logic                 mispredict_o,
    output riscv_pkg::word_t     redirect_pc_o
);

    import riscv_pkg::*;

    // update register, only the valid flag is control state
    logic                 upd_valid_q;
    word_t                upd_pc_q;
    opcode_t              upd_op_q;
    logic                 upd_taken_q;
    word_t                upd_target_q;
    logic [GHR_BITS-1:0]  upd_index_q;
    logic                 upd_pred_taken_q;
    word_t                upd_pred_target_q;

    logic                 is_branch;
    logic                 is_jump;
    logic                 dir_wrong;
    logic                 target_wrong;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= resolve_valid_i;
        end
    end

    // payload is captured on every strobe, back to back strobes just overwrite it
    always_ff @(posedge clk) begin
        if (resolve_valid_i) begin
            upd_pc_q          <= resolve_pc_i;
            upd_op_q          <= resolve_op_i;
            upd_taken_q       <= resolve_taken_i;
            upd_target_q      <= resolve_target_i;
            upd_index_q       <= resolve_pht_index_i;
            upd_pred_taken_q  <= resolve_pred_taken_i;
            upd_pred_target_q <= resolve_pred_target_i;
        end
    end

    // opcode class of the registered outcome
    assign is_branch = (upd_op_q == OP_BRANCH);
    assign is_jump   = (upd_op_q == OP_JAL) || (upd_op_q == OP_JALR);

    // the BTB only learns instructions that actually redirect fetch
    assign btb_we_o     = upd_valid_q && (is_jump || (is_branch && upd_taken_q));
    assign btb_pc_o     = upd_pc_q;
    assign btb_target_o = upd_target_q;

    // jumps are always taken, so only conditional branches train the counters
    // and the history
    assign pht_we_o        = upd_valid_q && is_branch;
    assign pht_increment_o = upd_taken_q;
    assign pht_index_o     = upd_index_q;

    // wrong direction, or right direction but fetch went to the wrong place
    assign dir_wrong    = (upd_taken_q != upd_pred_taken_q);
    assign target_wrong = upd_taken_q && upd_pred_taken_q
                          && (upd_target_q != upd_pred_target_q);
    assign mispredict_o = upd_valid_q && (dir_wrong || target_wrong);

    // fetch restarts at the real target, or falls through after a not taken branch
    assign redirect_pc_o = upd_taken_q ? upd_target_q : word_t'(upd_pc_q + 32'd4);

    // execute only resolves branches and jumps, so a redirect must come from
    // an update register that holds a real control transfer
    property p_mispredict_has_entry;
        @(posedge clk) disable iff (reset_i)
        mispredict_o |-> (is_branch || is_jump);
    endproperty

    a_mispredict_has_entry: assert property (p_mispredict_has_entry)
        else $error("mispredict from an outcome that is neither a branch nor a jump");

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/100ps

// branch prediction unit for the fetch stage
// the BTB and the gshare predictor are read with the fetch pc in the same
// cycle, the update controller trains both from outcomes resolved in execute
module branch_unit #(
    parameter int BTB_ENTRIES = 64,
    parameter int GHR_BITS    = 6
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  riscv_pkg::word_t     fetch_pc_i,
    input  riscv_pkg::opcode_t   fetch_op_i,
    output logic                 pred_taken_o,
    output riscv_pkg::word_t     pred_target_o,
    output logic [GHR_BITS-1:0]  pred_pht_index_o,
    input  logic                 ghr_clear_i,
    input  logic                 resolve_valid_i,
    input  riscv_pkg::word_t     resolve_pc_i,
    input  riscv_pkg::opcode_t   resolve_op_i,
    input  logic                 resolve_taken_i,
    input  riscv_pkg::word_t     resolve_target_i,
    input  logic [GHR_BITS-1:0]  resolve_pht_index_i,
    input  logic                 resolve_pred_taken_i,
    input  riscv_pkg::word_t     resolve_pred_target_i,
    output logic                 mispredict_o,
    output riscv_pkg::word_t     redirect_pc_o
);

    import riscv_pkg::*;

    // lookup results for the fetch pc
    logic                 btb_hit;
    word_t                btb_target;
    logic                 pht_taken;
    logic                 fetch_is_jump;

    // table writes from the update controller
    logic                 btb_we;
    word_t                btb_pc;
    word_t                btb_wtarget;
    logic                 pht_we;
    logic                 pht_increment;
    logic [GHR_BITS-1:0]  pht_index;

    branch_target_buffer #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) btb_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .lookup_pc_i    (fetch_pc_i),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .we_i           (btb_we),
        .write_pc_i     (btb_pc),
        .write_target_i (btb_wtarget)
    );

    gshare_predictor #(
        .GHR_BITS (GHR_BITS)
    ) gshare_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (fetch_pc_i),
        .read_index_o    (pred_pht_index_o),
        .predict_taken_o (pht_taken),
        .ghr_clear_i     (ghr_clear_i),
        .we_i            (pht_we),
        .increment_i     (pht_increment),
        .write_index_i   (pht_index)
    );

    bpred_update_ctrl #(
        .GHR_BITS (GHR_BITS)
    ) update_i (
        .clk                   (clk),
        .reset_i               (reset_i),
        .resolve_valid_i       (resolve_valid_i),
        .resolve_pc_i          (resolve_pc_i),
        .resolve_op_i          (resolve_op_i),
        .resolve_taken_i       (resolve_taken_i),
        .resolve_target_i      (resolve_target_i),
        .resolve_pht_index_i   (resolve_pht_index_i),
        .resolve_pred_taken_i  (resolve_pred_taken_i),
        .resolve_pred_target_i (resolve_pred_target_i),
        .btb_we_o              (btb_we),
        .btb_pc_o              (btb_pc),
        .btb_target_o          (btb_wtarget),
        .pht_we_o              (pht_we),
        .pht_increment_o       (pht_increment),
        .pht_index_o           (pht_index),
        .mispredict_o          (mispredict_o),
        .redirect_pc_o         (redirect_pc_o)
    );

    assign fetch_is_jump = (fetch_op_i == OP_JAL) || (fetch_op_i == OP_JALR);

    // a miss falls through to pc+4 not taken
    // a hit on a jump is always taken, a hit on anything else asks the counter
    assign pred_taken_o  = btb_hit && (fetch_is_jump || pht_taken);
    assign pred_target_o = btb_hit ? btb_target : word_t'(fetch_pc_i + 32'd4);

endmodule

//--- dv/branch_unit_tb.sv
`timescale 1ns/100ps

// directed testbench for the branch prediction unit
// a reference model of the BTB, the counter table and the history follows
// every resolve, and each prediction of the DUT is compared with it
module branch_unit_tb;

    import riscv_pkg::*;
    import bpred_pkg::*;

    localparam int BTB_ENTRIES = 64;
    localparam int GHR_BITS    = 6;
    localparam int IDX_BITS    = $clog2(BTB_ENTRIES);
    localparam int CLK_PERIOD  = 100;
    // cycle budgets of reset and the six tests, then some slack on top
    localparam int RUN_CYCLES  = 8 + 20 + 20 + 30 + 130 + 25 + 25 + 50;

    logic clk;
    logic reset_i;
    word_t fetch_pc_i;
    opcode_t fetch_op_i;
    logic pred_taken_o;
    word_t pred_target_o;
    logic [GHR_BITS-1:0] pred_pht_index_o;
    logic ghr_clear_i;
    logic resolve_valid_i;
    word_t resolve_pc_i;
    opcode_t resolve_op_i;
    logic resolve_taken_i;
    word_t resolve_target_i;
    logic [GHR_BITS-1:0] resolve_pht_index_i;
    logic resolve_pred_taken_i;
    word_t resolve_pred_target_i;
    logic mispredict_o;
    word_t redirect_pc_o;

    // reference model state
    logic m_valid [BTB_ENTRIES];
    logic [29-IDX_BITS:0] m_tag [BTB_ENTRIES];
    word_t m_target [BTB_ENTRIES];
    ctr_t m_pht [1 << GHR_BITS];
    logic [GHR_BITS-1:0] m_ghr;
    int unsigned lcg_state = 51189;

    branch_unit #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .GHR_BITS    (GHR_BITS)
    ) branch_unit_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        report_failure("watchdog expired before the tests finished");
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // gshare index as fetch sees it right now
    function automatic logic [GHR_BITS-1:0] model_index(input word_t pc);
        return m_ghr ^ pc[GHR_BITS+1:2];
    endfunction

    function automatic logic model_hit(input word_t pc);
        return m_valid[pc[IDX_BITS+1:2]] && (m_tag[pc[IDX_BITS+1:2]] == pc[31:IDX_BITS+2]);
    endfunction

    // jumps that hit are always taken, other hits follow the counter's upper bit
    function automatic logic model_taken(input word_t pc, input opcode_t op);
        return model_hit(pc) && (op == OP_JAL || op == OP_JALR || m_pht[model_index(pc)][1]);
    endfunction

    function automatic word_t model_target(input word_t pc);
        return model_hit(pc) ? m_target[pc[IDX_BITS+1:2]] : pc + 32'd4;
    endfunction

    // moves to 10 ns after the next rising edge, where every input changes
    // strobes and the history clear fall back to idle unless a caller raises them
    task automatic next_cycle();
        @(posedge clk);
        #10;
        resolve_valid_i = 1'b0;
        ghr_clear_i = 1'b0;
    endtask

    // a prediction made a cycle after the last table edge, checked mid cycle
    task automatic check_prediction(input word_t pc, input opcode_t op);
        next_cycle();
        fetch_pc_i = pc;
        fetch_op_i = op;
        #40;
        check_value("pred_taken_o", 32'(pred_taken_o), 32'(model_taken(pc, op)));
        check_value("pred_target_o", pred_target_o, model_target(pc));
        check_value("pred_pht_index_o", 32'(pred_pht_index_o), 32'(model_index(pc)));
    endtask

    // one resolve strobe, then the mispredict check in the cycle after the strobe edge
    task automatic resolve_outcome(input word_t pc, input opcode_t op, input logic taken,
                                   input word_t target, input logic ptaken, input word_t ptarget,
                                   input logic clear);
        logic [GHR_BITS-1:0] idx;
        logic [IDX_BITS-1:0] bidx;
        logic exp_mis;
        idx = model_index(pc);
        bidx = pc[IDX_BITS+1:2];
        exp_mis = (taken != ptaken) || (taken && ptaken && (target != ptarget));
        next_cycle();
        resolve_valid_i = 1'b1;
        resolve_pc_i = pc;
        resolve_op_i = op;
        resolve_taken_i = taken;
        resolve_target_i = target;
        resolve_pht_index_i = idx;
        resolve_pred_taken_i = ptaken;
        resolve_pred_target_i = ptarget;
        next_cycle();
        ghr_clear_i = clear;
        // taken branches and all jumps install, only branches train the counters
        if (op == OP_JAL || op == OP_JALR || (op == OP_BRANCH && taken)) begin
            m_valid[bidx] = 1'b1;
            m_tag[bidx] = pc[31:IDX_BITS+2];
            m_target[bidx] = target;
        end
        if (op == OP_BRANCH) begin
            if (taken && m_pht[idx] != CTR_MAX) begin
                m_pht[idx] = ctr_t'(m_pht[idx] + 2'd1);
            end else if (!taken && m_pht[idx] != CTR_MIN) begin
                m_pht[idx] = ctr_t'(m_pht[idx] - 2'd1);
            end
            m_ghr = {m_ghr[GHR_BITS-2:0], taken};
        end
        // a clear at the same edge wins over the shift
        if (clear) begin
            m_ghr = '0;
        end
        #40;
        check_value("mispredict_o", 32'(mispredict_o), 32'(exp_mis));
        if (exp_mis) begin
            check_value("redirect_pc_o", redirect_pc_o, taken ? target : pc + 32'd4);
        end
    endtask

    task automatic clear_history();
        next_cycle();
        ghr_clear_i = 1'b1;
        m_ghr = '0;
    endtask

    task automatic check_no_mispredict();
        next_cycle();
        #40;
        check_value("mispredict_o", 32'(mispredict_o), 32'd0);
    endtask

    // with an empty BTB every opcode falls through, and the index is the bare pc bits
    task automatic test_reset_defaults();
        opcode_t ops [4];
        logic [31:0] r;
        word_t pc;
        ops = '{OP_BRANCH, OP_JAL, OP_JALR, 7'b0110011};
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            pc = {r[31:2], 2'b00};
            check_prediction(pc, ops[i[1:0]]);
            check_value("pred_pht_index_o", 32'(pred_pht_index_o), 32'(pc[GHR_BITS+1:2]));
            check_value("mispredict_o", 32'(mispredict_o), 32'd0);
        end
    endtask

    task automatic test_jal_install();
        word_t pc;
        word_t target;
        pc = 32'h0000_1040;
        target = 32'h0000_2000;
        check_prediction(pc, OP_JAL);
        resolve_outcome(pc, OP_JAL, 1'b1, target, 1'b0, pc + 32'd4, 1'b0);
        check_prediction(pc, OP_JAL);
        check_value("pred_taken_o", 32'(pred_taken_o), 32'd1);
        check_value("pred_target_o", pred_target_o, target);
        // same index bits, tag bit 16 flipped
        check_prediction(pc ^ 32'h0001_0000, OP_JAL);
        check_value("pred_taken_o", 32'(pred_taken_o), 32'd0);
    endtask

    task automatic test_branch_direction();
        word_t pc;
        pc = 32'h0000_3008;
        resolve_outcome(pc, OP_BRANCH, 1'b1, 32'h0000_3100, 1'b0, pc + 32'd4, 1'b0);
        check_prediction(pc, OP_BRANCH);
        // back to history zero to read the trained counter again
        clear_history();
        check_prediction(pc, OP_BRANCH);
        check_value("pred_taken_o", 32'(pred_taken_o), 32'd1);
        // not taken outcomes shift zeros in, so the index stays put
        for (int i = 0; i < 3; i++) begin
            resolve_outcome(pc, OP_BRANCH, 1'b0, 32'h0000_3100,
                            model_taken(pc, OP_BRANCH), model_target(pc), 1'b0);
            check_prediction(pc, OP_BRANCH);
        end
        check_value("pred_taken_o", 32'(pred_taken_o), 32'd0);
    endtask

    task automatic test_random_training();
        word_t pcs [4];
        logic [31:0] r;
        word_t pc;
        logic taken;
        for (int k = 0; k < 4; k++) begin
            r = lcg_next();
            pcs[k] = {16'h0001, r[15:2], 2'b00};
        end
        for (int i = 0; i < 40; i++) begin
            r = lcg_next();
            pc = pcs[r[25:24]];
            taken = r[17];
            check_prediction(pc, OP_BRANCH);
            resolve_outcome(pc, OP_BRANCH, taken, pc + 32'h80,
                            model_taken(pc, OP_BRANCH), model_target(pc), 1'b0);
        end
    endtask

    task automatic test_mispredict();
        word_t pc;
        word_t target;
        pc = 32'h0000_5010;
        target = 32'h0000_5400;
        resolve_outcome(pc, OP_BRANCH, 1'b1, target, 1'b0, pc + 32'd4, 1'b0);
        check_no_mispredict();
        // wrong direction redirects to the fall through pc
        resolve_outcome(pc, OP_BRANCH, 1'b0, target, 1'b1, target, 1'b0);
        check_no_mispredict();
        // right direction but a stale target
        resolve_outcome(pc, OP_BRANCH, 1'b1, target, 1'b1, target + 32'd8, 1'b0);
        resolve_outcome(pc, OP_BRANCH, 1'b1, target, 1'b1, target, 1'b0);
    endtask

    task automatic test_history_clear();
        word_t pc;
        pc = 32'h0000_6020;
        clear_history();
        resolve_outcome(pc, OP_BRANCH, 1'b1, 32'h0000_6200, 1'b0, pc + 32'd4, 1'b0);
        // a second taken outcome at history zero leaves the counter at 10 or above
        // whatever earlier tests left in that entry
        clear_history();
        resolve_outcome(pc, OP_BRANCH, 1'b1, 32'h0000_6200,
                        model_taken(pc, OP_BRANCH), model_target(pc), 1'b0);
        check_prediction(pc, OP_BRANCH);
        clear_history();
        check_prediction(pc, OP_BRANCH);
        check_value("pred_pht_index_o", 32'(pred_pht_index_o), 32'(pc[GHR_BITS+1:2]));
        check_value("pred_taken_o", 32'(pred_taken_o), 32'd1);
        resolve_outcome(pc, OP_BRANCH, 1'b1, 32'h0000_6200, 1'b1, 32'h0000_6200, 1'b1);
        check_prediction(pc, OP_BRANCH);
        check_value("pred_pht_index_o", 32'(pred_pht_index_o), 32'(pc[GHR_BITS+1:2]));
    endtask

    initial begin
        reset_i = 1'b1;
        fetch_pc_i = '0;
        fetch_op_i = '0;
        ghr_clear_i = 1'b0;
        resolve_valid_i = 1'b0;
        resolve_pc_i = '0;
        resolve_op_i = '0;
        resolve_taken_i = 1'b0;
        resolve_target_i = '0;
        resolve_pht_index_i = '0;
        resolve_pred_taken_i = 1'b0;
        resolve_pred_target_i = '0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << GHR_BITS); i++) begin
            m_pht[i] = CTR_RESET;
        end
        m_ghr = '0;
        repeat (8) @(posedge clk);
        #10;
        reset_i = 1'b0;
        test_reset_defaults();
        test_jal_install();
        test_branch_direction();
        test_random_training();
        test_mispredict();
        test_history_clear();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
verilog/riscv_pkg.sv
verilog/bpred_pkg.sv
verilog/branch_target_buffer.sv
verilog/gshare_predictor.sv
verilog/bpred_update_ctrl.sv
verilog/branch_unit.sv
dv/branch_unit_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f verilog.f \
        --top-module branch_unit_tb -Mdir obj_dir \
    && ./obj_dir/Vbranch_unit_tb \
    || { echo "simulation failed"; exit 1; }
